//--- spidergon_pkg.sv
// spidergon node shared definitions
package spidergon_pkg;

	// ring geometry and buffering
	localparam int num_nodes = 8;
	localparam int num_ports = 3;
	localparam int num_vcs = 2;
	localparam int fifo_depth = 2;
	localparam int fifo_ptr_width = $clog2(fifo_depth);
	localparam int fifo_count_width = $clog2(fifo_depth + 1);

	// flit layout, type code on top and the channel field just under the payload msb
	localparam int flit_data_width = 16;
	localparam int flit_kind_width = 2;
	localparam int flit_width = flit_kind_width + flit_data_width;
	localparam int flit_vc_bit = 15;
	// destination node only means something in head and header flits
	localparam int flit_dest_msb = 14;
	localparam int flit_dest_lsb = 12;

	// link port numbering, shared by the input and output sides
	localparam int port_anticlockwise = 0;
	localparam int port_clockwise = 1;
	localparam int port_across = 2;

	typedef logic [flit_width-1:0] flit_t;
	typedef logic [flit_kind_width-1:0] flit_kind_t;
	typedef logic [$clog2(num_nodes)-1:0] node_id_t;
	typedef logic [$clog2(num_vcs)-1:0] vc_idx_t;
	typedef logic [$clog2(num_ports)-1:0] port_idx_t;
	typedef logic [num_ports-1:0] port_vec_t;
	// channel vectors are port major, so bit p*num_vcs+v is channel v of port p
	typedef logic [num_ports*num_vcs-1:0] vc_vec_t;

	// flit type codes
	localparam flit_kind_t kind_tail = 2'b00;
	localparam flit_kind_t kind_head = 2'b01;
	localparam flit_kind_t kind_body = 2'b10;
	localparam flit_kind_t kind_header = 2'b11;

	// output direction held by the injection side between head and tail
	typedef enum logic [1:0] {
		route_stop,
		route_clockwise,
		route_anticlockwise,
		route_across
	} route_t;

endpackage

//--- vc_fifo.sv
// virtual channel flit buffer
`timescale 1ns/100ps

module vc_fifo
(
	input logic clk,
	input logic reset,
	input logic push,
	input spidergon_pkg::flit_t push_flit,
	input logic pop,
	output spidergon_pkg::flit_t head_flit,
	output logic full,
	output logic empty
);

	spidergon_pkg::flit_t mem [spidergon_pkg::fifo_depth];
	logic [spidergon_pkg::fifo_ptr_width-1:0] rd_ptr;
	logic [spidergon_pkg::fifo_ptr_width-1:0] wr_ptr;
	logic [spidergon_pkg::fifo_count_width-1:0] count;
	logic do_push;
	logic do_pop;

	// pointers wrap at the buffer depth, which need not be a power of two
	function automatic logic [spidergon_pkg::fifo_ptr_width-1:0] next_ptr
	(
		input logic [spidergon_pkg::fifo_ptr_width-1:0] ptr
	);
		if (ptr == spidergon_pkg::fifo_depth - 1)
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = (count == spidergon_pkg::fifo_depth);
	assign empty = (count == '0);

	// a push into a full buffer or a pop from an empty one does nothing
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// the oldest flit is always visible to the ejection side
	assign head_flit = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// push and pop in the same cycle leave the count alone
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- input_vc_alloc.sv
// input port channel allocator
`timescale 1ns/100ps

module input_vc_alloc
(
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t in_flit,
	input logic in_valid,
	input logic [spidergon_pkg::num_vcs-1:0] fifo_full,
	output logic [spidergon_pkg::num_vcs-1:0] push,
	output spidergon_pkg::flit_t push_flit,
	output logic [spidergon_pkg::num_vcs-1:0] vc_ready
);

	spidergon_pkg::flit_kind_t kind;
	spidergon_pkg::vc_idx_t vc_field;
	logic opens;
	logic follows;
	logic [spidergon_pkg::num_vcs-1:0] reserved;
	spidergon_pkg::vc_idx_t owner [spidergon_pkg::num_vcs];
	logic [spidergon_pkg::num_vcs-1:0] eligible;
	logic [spidergon_pkg::num_vcs-1:0] target;

	assign kind = in_flit[spidergon_pkg::flit_width-1 -: spidergon_pkg::flit_kind_width];
	// channel index the packet used at the previous node
	assign vc_field = in_flit[spidergon_pkg::flit_vc_bit];

	// heads and headers look for a free channel, body and tail flits for their packet's one
	assign opens = (kind == spidergon_pkg::kind_head) || (kind == spidergon_pkg::kind_header);
	assign follows = (kind == spidergon_pkg::kind_body) || (kind == spidergon_pkg::kind_tail);

	always_comb
	begin
		for (int i = 0; i < spidergon_pkg::num_vcs; i++)
		begin
			if (opens)
				eligible[i] = !reserved[i];
			else if (follows)
				eligible[i] = reserved[i] && (owner[i] == vc_field);
			else
				eligible[i] = 1'b0;
		end
	end

	// lowest numbered eligible channel wins
	always_comb
	begin
		target = '0;
		for (int i = 0; i < spidergon_pkg::num_vcs; i++)
		begin
			if (eligible[i] && (target == '0))
				target[i] = 1'b1;
		end
	end

	// a flit that finds no channel or a full one is simply lost
	assign push = {spidergon_pkg::num_vcs{in_valid}} & target & ~fifo_full;
	assign push_flit = in_flit;
	assign vc_ready = ~reserved;

	// reservation follows the enqueue, so a dropped head reserves nothing
	always_ff @(posedge clk)
	begin
		if (reset)
			reserved <= '0;
		else
		begin
			for (int i = 0; i < spidergon_pkg::num_vcs; i++)
			begin
				if (push[i] && (kind == spidergon_pkg::kind_head))
					reserved[i] <= 1'b1;
				else if (push[i] && (kind == spidergon_pkg::kind_tail))
					reserved[i] <= 1'b0;
			end
		end
	end

	// owner tag is only looked at while its channel is reserved
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < spidergon_pkg::num_vcs; i++)
		begin
			if (push[i] && (kind == spidergon_pkg::kind_head))
				owner[i] <= vc_field;
		end
	end

endmodule

//--- rr_arbiter.sv
// round robin arbiter
`timescale 1ns/100ps

module rr_arbiter
#(
	parameter int width = 2
)
(
	input logic clk,
	input logic reset,
	input logic [width-1:0] req,
	input logic advance,
	output logic [width-1:0] grant
);

	// mask has every bit at or above the priority pointer set
	logic [width-1:0] mask;
	logic [width-1:0] masked_req;

	assign masked_req = req & mask;

	// first requester at or after the pointer, else wrap to the lowest requester
	always_comb
	begin
		grant = '0;
		for (int i = 0; i < width; i++)
		begin
			if (masked_req[i] && (grant == '0))
				grant[i] = 1'b1;
		end
		for (int i = 0; i < width; i++)
		begin
			if (req[i] && (grant == '0))
				grant[i] = 1'b1;
		end
	end

	// moving past the top requester empties the mask, which is the same as pointing at bit 0
	always_ff @(posedge clk)
	begin
		if (reset)
			mask <= '1;
		else if (advance && (|req))
			mask <= ~((grant << 1) - 1'b1);
	end

endmodule

//--- ejection_arbiter.sv
// ejection to the local cpu
`timescale 1ns/100ps

module ejection_arbiter
(
	input logic clk,
	input logic reset,
	input spidergon_pkg::vc_vec_t fifo_empty,
	input spidergon_pkg::flit_t fifo_head [spidergon_pkg::num_ports*spidergon_pkg::num_vcs],
	output spidergon_pkg::vc_vec_t pop,
	output spidergon_pkg::flit_t to_cpu,
	output logic to_cpu_valid,
	output spidergon_pkg::port_idx_t to_cpu_port,
	output spidergon_pkg::vc_idx_t to_cpu_vc
);

	spidergon_pkg::port_vec_t port_req;
	spidergon_pkg::port_vec_t port_grant;
	logic [spidergon_pkg::num_vcs-1:0] vc_req;
	logic [spidergon_pkg::num_vcs-1:0] vc_grant;
	spidergon_pkg::port_idx_t port_sel;
	spidergon_pkg::vc_idx_t vc_sel;
	logic any_req;

	// a port asks for the cpu when any of its channels holds a flit
	always_comb
	begin
		for (int p = 0; p < spidergon_pkg::num_ports; p++)
			port_req[p] = !(&fifo_empty[p*spidergon_pkg::num_vcs +: spidergon_pkg::num_vcs]);
	end

	assign any_req = |port_req;

	rr_arbiter #(.width(spidergon_pkg::num_ports)) u_port_arb
	(
		.clk(clk),
		.reset(reset),
		.req(port_req),
		.advance(any_req),
		.grant(port_grant)
	);

	always_comb
	begin
		port_sel = '0;
		for (int p = 0; p < spidergon_pkg::num_ports; p++)
		begin
			if (port_grant[p])
				port_sel = spidergon_pkg::port_idx_t'(p);
		end
	end

	// second stage only sees the channels of the winning port
	// and its pointer is shared by all ports
	assign vc_req = ~fifo_empty[port_sel*spidergon_pkg::num_vcs +: spidergon_pkg::num_vcs];

	rr_arbiter #(.width(spidergon_pkg::num_vcs)) u_vc_arb
	(
		.clk(clk),
		.reset(reset),
		.req(vc_req),
		.advance(any_req),
		.grant(vc_grant)
	);

	always_comb
	begin
		vc_sel = '0;
		for (int v = 0; v < spidergon_pkg::num_vcs; v++)
		begin
			if (vc_grant[v])
				vc_sel = spidergon_pkg::vc_idx_t'(v);
		end
	end

	// exactly one pop whenever something is buffered, since the cpu never stalls
	always_comb
	begin
		pop = '0;
		if (any_req)
			pop[port_sel*spidergon_pkg::num_vcs + vc_sel] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			to_cpu_valid <= 1'b0;
		else
			to_cpu_valid <= any_req;
	end

	// flit and its origin are captured at the same edge as the pop
	always_ff @(posedge clk)
	begin
		if (any_req)
		begin
			to_cpu <= fifo_head[port_sel*spidergon_pkg::num_vcs + vc_sel];
			to_cpu_port <= port_sel;
			to_cpu_vc <= vc_sel;
		end
	end

endmodule

//--- injection_router.sv
// cpu injection and routing
`timescale 1ns/100ps

module injection_router
#(
	parameter spidergon_pkg::node_id_t node_id = '0
)
(
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t from_cpu,
	input logic from_cpu_valid,
	output spidergon_pkg::flit_t out_flit_clockwise,
	output spidergon_pkg::flit_t out_flit_anticlockwise,
	output spidergon_pkg::flit_t out_flit_across,
	output spidergon_pkg::port_vec_t out_valid
);

	spidergon_pkg::flit_kind_t kind;
	spidergon_pkg::node_id_t dest;
	spidergon_pkg::node_id_t offset;
	spidergon_pkg::route_t head_route;
	spidergon_pkg::route_t route_q;
	spidergon_pkg::route_t route;
	spidergon_pkg::flit_t link_flit;
	logic opens;

	assign kind = from_cpu[spidergon_pkg::flit_width-1 -: spidergon_pkg::flit_kind_width];
	assign dest = from_cpu[spidergon_pkg::flit_dest_msb:spidergon_pkg::flit_dest_lsb];
	assign opens = (kind == spidergon_pkg::kind_head) || (kind == spidergon_pkg::kind_header);

	// node ids wrap in their own width, so the subtraction is already mod num_nodes
	assign offset = dest - node_id;

	// shortest path, a quarter of the ring each way and the across link for the rest
	always_comb
	begin
		if (offset == '0)
			head_route = spidergon_pkg::route_stop;
		else if (offset <= spidergon_pkg::num_nodes / 4)
			head_route = spidergon_pkg::route_clockwise;
		else if (offset >= spidergon_pkg::num_nodes - spidergon_pkg::num_nodes / 4)
			head_route = spidergon_pkg::route_anticlockwise;
		else
			head_route = spidergon_pkg::route_across;
	end

	// body and tail flits ride on whatever the head latched
	assign route = opens ? head_route : route_q;

	// headers route themselves and leave the latched route untouched
	always_ff @(posedge clk)
	begin
		if (reset)
			route_q <= spidergon_pkg::route_stop;
		else if (from_cpu_valid && (kind == spidergon_pkg::kind_head))
			route_q <= head_route;
		else if (from_cpu_valid && (kind == spidergon_pkg::kind_tail))
			route_q <= spidergon_pkg::route_stop;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= '0;
		else
		begin
			out_valid[spidergon_pkg::port_clockwise] <= from_cpu_valid &&
				(route == spidergon_pkg::route_clockwise);
			out_valid[spidergon_pkg::port_anticlockwise] <= from_cpu_valid &&
				(route == spidergon_pkg::route_anticlockwise);
			out_valid[spidergon_pkg::port_across] <= from_cpu_valid &&
				(route == spidergon_pkg::route_across);
		end
	end

	// one flit register feeds all links, out_valid says which link owns it
	always_ff @(posedge clk)
	begin
		if (from_cpu_valid)
			link_flit <= from_cpu;
	end

	assign out_flit_clockwise = link_flit;
	assign out_flit_anticlockwise = link_flit;
	assign out_flit_across = link_flit;

endmodule

//--- spidergon_node.sv
// spidergon network node
`timescale 1ns/100ps

module spidergon_node
#(
	parameter spidergon_pkg::node_id_t node_id = '0
)
(
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t in_flit_clockwise,
	input spidergon_pkg::flit_t in_flit_anticlockwise,
	input spidergon_pkg::flit_t in_flit_across,
	input spidergon_pkg::port_vec_t in_valid,
	output spidergon_pkg::vc_vec_t vc_ready,
	output spidergon_pkg::vc_vec_t vc_full,
	output spidergon_pkg::flit_t to_cpu,
	output logic to_cpu_valid,
	output spidergon_pkg::port_idx_t to_cpu_port,
	output spidergon_pkg::vc_idx_t to_cpu_vc,
	input spidergon_pkg::flit_t from_cpu,
	input logic from_cpu_valid,
	output spidergon_pkg::flit_t out_flit_clockwise,
	output spidergon_pkg::flit_t out_flit_anticlockwise,
	output spidergon_pkg::flit_t out_flit_across,
	output spidergon_pkg::port_vec_t out_valid
);

	spidergon_pkg::flit_t port_flit [spidergon_pkg::num_ports];
	spidergon_pkg::flit_t push_flit [spidergon_pkg::num_ports];
	spidergon_pkg::flit_t fifo_head [spidergon_pkg::num_ports*spidergon_pkg::num_vcs];
	spidergon_pkg::vc_vec_t push;
	spidergon_pkg::vc_vec_t pop;
	spidergon_pkg::vc_vec_t fifo_empty;

	// link inputs indexed by port number
	assign port_flit[spidergon_pkg::port_anticlockwise] = in_flit_anticlockwise;
	assign port_flit[spidergon_pkg::port_clockwise] = in_flit_clockwise;
	assign port_flit[spidergon_pkg::port_across] = in_flit_across;

	for (genvar p = 0; p < spidergon_pkg::num_ports; p++)
	begin : g_port
		input_vc_alloc u_alloc
		(
			.clk(clk),
			.reset(reset),
			.in_flit(port_flit[p]),
			.in_valid(in_valid[p]),
			.fifo_full(vc_full[p*spidergon_pkg::num_vcs +: spidergon_pkg::num_vcs]),
			.push(push[p*spidergon_pkg::num_vcs +: spidergon_pkg::num_vcs]),
			.push_flit(push_flit[p]),
			.vc_ready(vc_ready[p*spidergon_pkg::num_vcs +: spidergon_pkg::num_vcs])
		);

		// the full flags go straight out so senders can see them
		for (genvar v = 0; v < spidergon_pkg::num_vcs; v++)
		begin : g_vc
			vc_fifo u_fifo
			(
				.clk(clk),
				.reset(reset),
				.push(push[p*spidergon_pkg::num_vcs + v]),
				.push_flit(push_flit[p]),
				.pop(pop[p*spidergon_pkg::num_vcs + v]),
				.head_flit(fifo_head[p*spidergon_pkg::num_vcs + v]),
				.full(vc_full[p*spidergon_pkg::num_vcs + v]),
				.empty(fifo_empty[p*spidergon_pkg::num_vcs + v])
			);
		end
	end

	ejection_arbiter u_eject
	(
		.clk(clk),
		.reset(reset),
		.fifo_empty(fifo_empty),
		.fifo_head(fifo_head),
		.pop(pop),
		.to_cpu(to_cpu),
		.to_cpu_valid(to_cpu_valid),
		.to_cpu_port(to_cpu_port),
		.to_cpu_vc(to_cpu_vc)
	);

	injection_router #(.node_id(node_id)) u_router
	(
		.clk(clk),
		.reset(reset),
		.from_cpu(from_cpu),
		.from_cpu_valid(from_cpu_valid),
		.out_flit_clockwise(out_flit_clockwise),
		.out_flit_anticlockwise(out_flit_anticlockwise),
		.out_flit_across(out_flit_across),
		.out_valid(out_valid)
	);

endmodule

//--- tb_clock.sv
// testbench clock source
`timescale 1ns/100ps

module tb_clock
#(
	parameter int period_ns = 40
)
(
	output logic clk
);

	// free running clock, first rising edge half a period after time zero
	initial
	begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

endmodule

//--- spidergon_node_assertions.sv
// spidergon node protocol checks
`timescale 1ns/100ps

module spidergon_node_assertions
(
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t in_flit_clockwise,
	input spidergon_pkg::flit_t in_flit_anticlockwise,
	input spidergon_pkg::flit_t in_flit_across,
	input spidergon_pkg::port_vec_t in_valid,
	input spidergon_pkg::vc_vec_t vc_ready,
	input spidergon_pkg::vc_vec_t vc_full,
	input spidergon_pkg::vc_vec_t push,
	input spidergon_pkg::flit_t to_cpu,
	input logic to_cpu_valid,
	input spidergon_pkg::port_vec_t out_valid
);

	spidergon_pkg::flit_t link_flit [spidergon_pkg::num_ports];
	spidergon_pkg::flit_t dropped [spidergon_pkg::num_ports];
	spidergon_pkg::port_vec_t dropped_valid;
	spidergon_pkg::port_vec_t dropped_hit;
	spidergon_pkg::port_vec_t head_strobe;
	int error_count = 0;

	assign link_flit[spidergon_pkg::port_anticlockwise] = in_flit_anticlockwise;
	assign link_flit[spidergon_pkg::port_clockwise] = in_flit_clockwise;
	assign link_flit[spidergon_pkg::port_across] = in_flit_across;

	always_comb
	begin
		for (int p = 0; p < spidergon_pkg::num_ports; p++)
		begin
			head_strobe[p] = in_valid[p] && (link_flit[p][spidergon_pkg::flit_width-1 -:
				spidergon_pkg::flit_kind_width] == spidergon_pkg::kind_head);
			dropped_hit[p] = dropped_valid[p] && (to_cpu == dropped[p]);
		end
	end

	// a strobed flit that no channel took is remembered per port
	always_ff @(posedge clk)
	begin
		if (reset)
			dropped_valid <= '0;
		else
		begin
			for (int p = 0; p < spidergon_pkg::num_ports; p++)
			begin
				if (in_valid[p] && (push[p*spidergon_pkg::num_vcs +: spidergon_pkg::num_vcs] == '0))
				begin
					dropped[p] <= link_flit[p];
					dropped_valid[p] <= 1'b1;
				end
			end
		end
	end

	// first edge out of reset sees every register at its reset value
	a_reset_state: assert property (@(posedge clk) $fell(reset) |->
		(out_valid == '0) && !to_cpu_valid && (&vc_ready) && (vc_full == '0))
	else
	begin
		$error("node state after reset is wrong");
		error_count++;
	end

	// a lost flit must never show up at the cpu
	a_no_dropped_delivery: assert property (@(posedge clk) disable iff (reset)
		to_cpu_valid |-> (dropped_hit == '0))
	else
	begin
		$error("a dropped flit was delivered to the cpu");
		error_count++;
	end

	// a channel is only taken by a head on its own port
	for (genvar c = 0; c < spidergon_pkg::num_ports * spidergon_pkg::num_vcs; c++)
	begin : g_ready
		a_ready_needs_head: assert property (@(posedge clk) disable iff (reset)
			$fell(vc_ready[c]) |-> $past(head_strobe[c / spidergon_pkg::num_vcs]))
		else
		begin
			$error("channel %0d reserved without a head flit", c);
			error_count++;
		end
	end

endmodule

bind spidergon_node spidergon_node_assertions u_assertions
(
	.clk(clk),
	.reset(reset),
	.in_flit_clockwise(in_flit_clockwise),
	.in_flit_anticlockwise(in_flit_anticlockwise),
	.in_flit_across(in_flit_across),
	.in_valid(in_valid),
	.vc_ready(vc_ready),
	.vc_full(vc_full),
	.push(push),
	.to_cpu(to_cpu),
	.to_cpu_valid(to_cpu_valid),
	.out_valid(out_valid)
);

//--- spidergon_node_tb.sv
// spidergon node testbench
`timescale 1ns/100ps

module spidergon_node_tb;

	localparam int clock_period = 40;
	localparam int num_tests = 6;
	localparam int num_chans = spidergon_pkg::num_ports * spidergon_pkg::num_vcs;
	localparam spidergon_pkg::node_id_t dut_node = 3'd0;

	logic clk;
	logic reset;
	spidergon_pkg::flit_t in_flit_clockwise;
	spidergon_pkg::flit_t in_flit_anticlockwise;
	spidergon_pkg::flit_t in_flit_across;
	spidergon_pkg::port_vec_t in_valid;
	spidergon_pkg::vc_vec_t vc_ready;
	spidergon_pkg::vc_vec_t vc_full;
	spidergon_pkg::flit_t to_cpu;
	logic to_cpu_valid;
	spidergon_pkg::port_idx_t to_cpu_port;
	spidergon_pkg::vc_idx_t to_cpu_vc;
	spidergon_pkg::flit_t from_cpu;
	logic from_cpu_valid;
	spidergon_pkg::flit_t out_flit_clockwise;
	spidergon_pkg::flit_t out_flit_anticlockwise;
	spidergon_pkg::flit_t out_flit_across;
	spidergon_pkg::port_vec_t out_valid;

	// flits queued for the next drive slot
	spidergon_pkg::flit_t next_flit [spidergon_pkg::num_ports];
	spidergon_pkg::port_vec_t next_valid;
	spidergon_pkg::flit_t next_cpu;
	logic next_cpu_valid;

	// reservation model of each input port, built from the allocation rules
	logic [spidergon_pkg::num_vcs-1:0] model_reserved [spidergon_pkg::num_ports];
	logic [spidergon_pkg::num_vcs-1:0] model_owner [spidergon_pkg::num_ports];

	// flits each channel holds, counted from enqueues and deliveries
	int occupancy [num_chans];

	// scoreboard, one entry per enqueued flit tagged with its channel number
	spidergon_pkg::flit_t exp_flit [$];
	int exp_chan [$];

	// link the cpu flit should leave on, checked one slot later
	spidergon_pkg::port_vec_t exp_out_valid;
	spidergon_pkg::flit_t exp_out_flit;
	spidergon_pkg::port_vec_t latched_link;

	int seed = 83085;
	logic [7:0] flit_seq;
	string test_name;
	int test_errors;
	int assert_base;
	int pass_count;
	int fail_count;

	tb_clock #(.period_ns(clock_period)) u_clock
	(
		.clk(clk)
	);

	spidergon_node #(.node_id(dut_node)) u_spidergon_node
	(
		.clk(clk),
		.reset(reset),
		.in_flit_clockwise(in_flit_clockwise),
		.in_flit_anticlockwise(in_flit_anticlockwise),
		.in_flit_across(in_flit_across),
		.in_valid(in_valid),
		.vc_ready(vc_ready),
		.vc_full(vc_full),
		.to_cpu(to_cpu),
		.to_cpu_valid(to_cpu_valid),
		.to_cpu_port(to_cpu_port),
		.to_cpu_vc(to_cpu_vc),
		.from_cpu(from_cpu),
		.from_cpu_valid(from_cpu_valid),
		.out_flit_clockwise(out_flit_clockwise),
		.out_flit_anticlockwise(out_flit_anticlockwise),
		.out_flit_across(out_flit_across),
		.out_valid(out_valid)
	);

	// low byte is a running number so every flit in the run is unique
	function automatic spidergon_pkg::flit_t new_flit
	(
		input spidergon_pkg::flit_kind_t kind,
		input logic vcf,
		input spidergon_pkg::node_id_t dest
	);
		logic [3:0] noise;
		noise = $random(seed);
		flit_seq = flit_seq + 1'b1;
		return {kind, vcf, dest, noise, flit_seq};
	endfunction

	// shortest path on the ring, offsets 1..2 clockwise, 6..7 anticlockwise, rest across
	function automatic spidergon_pkg::port_vec_t link_for_dest(input spidergon_pkg::node_id_t dest);
		int offset;
		spidergon_pkg::port_vec_t link;
		offset = (int'(dest) - int'(dut_node) + 8) % 8;
		link = '0;
		case (offset)
			1, 2: link[spidergon_pkg::port_clockwise] = 1'b1;
			3, 4, 5: link[spidergon_pkg::port_across] = 1'b1;
			6, 7: link[spidergon_pkg::port_anticlockwise] = 1'b1;
			default: link = '0;
		endcase
		return link;
	endfunction

	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Error in %s: %s expected %h, actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("Failure in %s: %s", test_name, what);
		test_errors++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
		assert_base = u_spidergon_node.u_assertions.error_count;
	endtask

	task automatic finish_test;
		if (u_spidergon_node.u_assertions.error_count != assert_base)
			report_problem("concurrent assertions fired during the test");
		if (test_errors == 0)
		begin
			$display("test %s passed", test_name);
			pass_count++;
		end
		else
		begin
			$display("test %s failed with %0d errors", test_name, test_errors);
			fail_count++;
		end
	endtask

	task automatic queue_link_flit(input int p, input spidergon_pkg::flit_t f);
		next_flit[p] = f;
		next_valid[p] = 1'b1;
	endtask

	task automatic queue_cpu_flit(input spidergon_pkg::flit_t f);
		next_cpu = f;
		next_cpu_valid = 1'b1;
	endtask

	// decide where the port puts the flit, or whether it loses it
	task automatic offer_flit(input int p, input spidergon_pkg::flit_t f);
		spidergon_pkg::flit_kind_t kind;
		logic vcf;
		int target;
		int chan;
		kind = f[spidergon_pkg::flit_width-1 -: spidergon_pkg::flit_kind_width];
		vcf = f[spidergon_pkg::flit_vc_bit];
		target = -1;
		// walk downwards so the lowest matching channel ends up chosen
		for (int v = spidergon_pkg::num_vcs - 1; v >= 0; v--)
		begin
			if ((kind == spidergon_pkg::kind_head || kind == spidergon_pkg::kind_header) &&
				!model_reserved[p][v])
				target = v;
			if ((kind == spidergon_pkg::kind_body || kind == spidergon_pkg::kind_tail) &&
				model_reserved[p][v] && (model_owner[p][v] == vcf))
				target = v;
		end
		// a full channel loses the flit, as does a packet with no channel
		if (target >= 0)
		begin
			chan = p * spidergon_pkg::num_vcs + target;
			if (occupancy[chan] < spidergon_pkg::fifo_depth)
			begin
				exp_flit.push_back(f);
				exp_chan.push_back(chan);
				occupancy[chan]++;
				if (kind == spidergon_pkg::kind_head)
				begin
					model_reserved[p][target] = 1'b1;
					model_owner[p][target] = vcf;
				end
				else if (kind == spidergon_pkg::kind_tail)
					model_reserved[p][target] = 1'b0;
			end
		end
	endtask

	task automatic check_links;
		spidergon_pkg::flit_t actual;
		compare_value("out_valid", exp_out_valid, out_valid);
		if (exp_out_valid != '0 && exp_out_valid == out_valid)
		begin
			if (exp_out_valid[spidergon_pkg::port_clockwise])
				actual = out_flit_clockwise;
			else if (exp_out_valid[spidergon_pkg::port_anticlockwise])
				actual = out_flit_anticlockwise;
			else
				actual = out_flit_across;
			compare_value("link flit", exp_out_flit, actual);
		end
	endtask

	task automatic check_ready;
		spidergon_pkg::vc_vec_t expected;
		for (int p = 0; p < spidergon_pkg::num_ports; p++)
			expected[p*spidergon_pkg::num_vcs +: spidergon_pkg::num_vcs] = ~model_reserved[p];
		compare_value("vc_ready", expected, vc_ready);
	endtask

	task automatic check_full;
		spidergon_pkg::vc_vec_t expected;
		for (int c = 0; c < num_chans; c++)
			expected[c] = (occupancy[c] == spidergon_pkg::fifo_depth);
		compare_value("vc_full", expected, vc_full);
	endtask

	// one clock of stimulus, checking what the previous slot should have caused
	task automatic step;
		spidergon_pkg::flit_kind_t kind;
		@(posedge clk);
		#2;
		// the flit now on the cpu port left its channel at this edge
		if (to_cpu_valid === 1'b1)
			occupancy[int'(to_cpu_port) * spidergon_pkg::num_vcs + int'(to_cpu_vc)]--;
		check_links();
		check_ready();
		check_full();
		for (int p = 0; p < spidergon_pkg::num_ports; p++)
		begin
			if (next_valid[p])
				offer_flit(p, next_flit[p]);
		end
		in_flit_anticlockwise = next_flit[spidergon_pkg::port_anticlockwise];
		in_flit_clockwise = next_flit[spidergon_pkg::port_clockwise];
		in_flit_across = next_flit[spidergon_pkg::port_across];
		in_valid = next_valid;
		from_cpu = next_cpu;
		from_cpu_valid = next_cpu_valid;
		// heads and headers pick their own link, the rest use the latched one
		exp_out_valid = '0;
		if (next_cpu_valid)
		begin
			kind = next_cpu[spidergon_pkg::flit_width-1 -: spidergon_pkg::flit_kind_width];
			if (kind == spidergon_pkg::kind_head || kind == spidergon_pkg::kind_header)
				exp_out_valid = link_for_dest(next_cpu[14:12]);
			else
				exp_out_valid = latched_link;
			if (kind == spidergon_pkg::kind_head)
				latched_link = exp_out_valid;
			else if (kind == spidergon_pkg::kind_tail)
				latched_link = '0;
			exp_out_flit = next_cpu;
		end
		next_valid = '0;
		next_cpu_valid = 1'b0;
	endtask

	// idle until the cpu has received everything expected
	task automatic drain;
		int n;
		n = 0;
		step();
		while (exp_flit.size() > 0 && n < 40)
		begin
			step();
			n++;
		end
		if (exp_flit.size() > 0)
			report_problem($sformatf("%0d flits never reached the cpu", exp_flit.size()));
	endtask

	// tails for any packet whose own tail was lost
	task automatic release_reservations;
		for (int p = 0; p < spidergon_pkg::num_ports; p++)
		begin
			for (int v = 0; v < spidergon_pkg::num_vcs; v++)
			begin
				if (model_reserved[p][v])
				begin
					queue_link_flit(p, new_flit(spidergon_pkg::kind_tail, model_owner[p][v], 3'd0));
					step();
				end
			end
		end
	endtask

	task automatic check_delivery;
		int chan;
		int idx;
		chan = int'(to_cpu_port) * spidergon_pkg::num_vcs + int'(to_cpu_vc);
		idx = -1;
		for (int i = exp_flit.size() - 1; i >= 0; i--)
		begin
			if (exp_chan[i] == chan)
				idx = i;
		end
		if (idx < 0)
			report_problem($sformatf("flit %h came from port %0d channel %0d with nothing expected",
				to_cpu, to_cpu_port, to_cpu_vc));
		else
		begin
			compare_value($sformatf("flit on channel %0d", chan), exp_flit[idx], to_cpu);
			exp_flit.delete(idx);
			exp_chan.delete(idx);
		end
	endtask

	// cpu outputs are registered, so the falling edge sees them settled
	always @(negedge clk)
	begin
		if (reset === 1'b0 && to_cpu_valid === 1'b1)
			check_delivery();
	end

	task automatic test_reset;
		begin_test("reset");
		compare_value("out_valid", '0, out_valid);
		compare_value("to_cpu_valid", 1'b0, to_cpu_valid);
		compare_value("vc_ready", {num_chans{1'b1}}, vc_ready);
		compare_value("vc_full", '0, vc_full);
		finish_test();
	endtask

	task automatic test_reservation;
		begin_test("reservation");
		queue_link_flit(spidergon_pkg::port_clockwise, new_flit(spidergon_pkg::kind_head, 1'b0, 3'd5));
		step();
		queue_link_flit(spidergon_pkg::port_clockwise, new_flit(spidergon_pkg::kind_head, 1'b1, 3'd6));
		step();
		step();
		queue_link_flit(spidergon_pkg::port_clockwise, new_flit(spidergon_pkg::kind_tail, 1'b0, 3'd0));
		step();
		step();
		queue_link_flit(spidergon_pkg::port_clockwise, new_flit(spidergon_pkg::kind_tail, 1'b1, 3'd0));
		step();
		drain();
		finish_test();
	endtask

	// two interleaved packets per port, one flit per slot rotating over the ports
	task automatic test_ordered_delivery;
		spidergon_pkg::flit_kind_t kind;
		begin_test("ordered_delivery");
		for (int i = 0; i < 6; i++)
		begin
			kind = (i < 2) ? spidergon_pkg::kind_head :
				(i < 4) ? spidergon_pkg::kind_body : spidergon_pkg::kind_tail;
			for (int p = 0; p < spidergon_pkg::num_ports; p++)
			begin
				queue_link_flit(p, new_flit(kind, i[0], $random(seed)));
				step();
			end
		end
		drain();
		finish_test();
	endtask

	// three flits a cycle against one delivery a cycle must overflow somewhere
	task automatic test_full_drop;
		spidergon_pkg::flit_kind_t kind;
		begin_test("full_drop");
		for (int i = 0; i < 6; i++)
		begin
			kind = (i == 0) ? spidergon_pkg::kind_head :
				(i == 5) ? spidergon_pkg::kind_tail : spidergon_pkg::kind_body;
			for (int p = 0; p < spidergon_pkg::num_ports; p++)
				queue_link_flit(p, new_flit(kind, p[0], $random(seed)));
			step();
		end
		drain();
		release_reservations();
		drain();
		finish_test();
	endtask

	task automatic test_injection;
		begin_test("injection");
		for (int d = 0; d < spidergon_pkg::num_nodes; d++)
		begin
			queue_cpu_flit(new_flit(spidergon_pkg::kind_head, 1'b0, d[2:0]));
			step();
			queue_cpu_flit(new_flit(spidergon_pkg::kind_body, 1'b0, $random(seed)));
			step();
			queue_cpu_flit(new_flit(spidergon_pkg::kind_tail, 1'b0, $random(seed)));
			step();
		end
		step();
		finish_test();
	endtask

	// a header between head and tail must not disturb the latched route
	task automatic test_header;
		begin_test("header");
		queue_cpu_flit(new_flit(spidergon_pkg::kind_head, 1'b0, 3'd1));
		step();
		queue_cpu_flit(new_flit(spidergon_pkg::kind_header, 1'b0, 3'd5));
		queue_link_flit(spidergon_pkg::port_across, new_flit(spidergon_pkg::kind_header, 1'b0, 3'd2));
		step();
		queue_cpu_flit(new_flit(spidergon_pkg::kind_tail, 1'b0, 3'd0));
		step();
		drain();
		compare_value("across vc_ready", 2'b11,
			vc_ready[spidergon_pkg::port_across*spidergon_pkg::num_vcs +: spidergon_pkg::num_vcs]);
		finish_test();
	endtask

	initial
	begin
		reset = 1'b1;
		in_flit_clockwise = '0;
		in_flit_anticlockwise = '0;
		in_flit_across = '0;
		in_valid = '0;
		from_cpu = '0;
		from_cpu_valid = 1'b0;
		next_valid = '0;
		next_cpu_valid = 1'b0;
		next_cpu = '0;
		exp_out_valid = '0;
		exp_out_flit = '0;
		latched_link = '0;
		flit_seq = '0;
		pass_count = 0;
		fail_count = 0;
		for (int p = 0; p < spidergon_pkg::num_ports; p++)
		begin
			next_flit[p] = '0;
			model_reserved[p] = '0;
			model_owner[p] = '0;
		end
		for (int c = 0; c < num_chans; c++)
			occupancy[c] = 0;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		test_reset();
		test_reservation();
		test_ordered_delivery();
		test_full_drop();
		test_injection();
		test_header();
		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && u_spidergon_node.u_assertions.error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// every test fits in 40 cycles, the extra 100 cover reset and slack
	initial
	begin
		#((num_tests * 40 + 100) * clock_period);
		$display("watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- all.f
spidergon_pkg.sv
vc_fifo.sv
input_vc_alloc.sv
rr_arbiter.sv
ejection_arbiter.sv
injection_router.sv
spidergon_node.sv
tb_clock.sv
spidergon_node_assertions.sv
spidergon_node_tb.sv
